// File: Bender.yml
package:
  name: alu_exec

sources:
  - files:
      - hw/mipsAluPkg.sv
      - hw/instrDecode.sv
      - hw/alu32.sv
      - hw/hiLoResult.sv
      - hw/aluExecTop.sv
  - target: test
    files:
      - dv/aluExecTb_asserts.sv
      - dv/aluExecTb.sv

// File: dv/aluExecTb.sv
`timescale 1ns/1ns

module aluExecTb;

	localparam int NumDirected = 46;
	localparam int NumRandom   = 400;
	localparam int CycleLimit  = (NumDirected + NumRandom) * 2 + 50; // Two cycles per item, slack

	// Funct and opcode pools for random words, 6 bits each
	localparam logic [77:0] RegFns = {mipsAluPkg::FnAdd, mipsAluPkg::FnAddu,
		mipsAluPkg::FnSub, mipsAluPkg::FnAnd, mipsAluPkg::FnOr, mipsAluPkg::FnXor,
		mipsAluPkg::FnNor, mipsAluPkg::FnSlt, mipsAluPkg::FnSltu, mipsAluPkg::FnMult,
		mipsAluPkg::FnMultu, mipsAluPkg::FnMfhi, mipsAluPkg::FnMflo};
	localparam logic [41:0] ImmOps = {mipsAluPkg::OpAddi, mipsAluPkg::OpAddiu,
		mipsAluPkg::OpSlti, mipsAluPkg::OpSltiu, mipsAluPkg::OpAndi,
		mipsAluPkg::OpOri, mipsAluPkg::OpXori};
	localparam logic [17:0] ShiftFns = {mipsAluPkg::FnSll, mipsAluPkg::FnSrl,
		mipsAluPkg::FnSra};

	logic               Clk;
	logic               reset;
	logic               inVld;
	mipsAluPkg::instrU  instr;
	logic [31:0]        rsData;
	logic [31:0]        rtData;
	logic               outVld;
	mipsAluPkg::resultS res;

	mipsAluPkg::resultS expQ[$]; // Predicted results, issue order
	string              nameQ[$];
	logic [31:0]        modelHi;
	logic [31:0]        modelLo;
	logic [31:0]        rng;
	int                 valErrors;
	int                 otherErrors;
	int                 cycles;

	aluExecTop u_dut (
		.Clk    (Clk),
		.reset  (reset),
		.inVld  (inVld),
		.instr  (instr),
		.rsData (rsData),
		.rtData (rtData),
		.outVld (outVld),
		.res    (res)
	);

	initial begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// ISA semantics straight from the word, HI/LO carried in and out
	function automatic mipsAluPkg::resultS refModel(input mipsAluPkg::instrU w,
		input logic [31:0] rs, input logic [31:0] rt,
		inout logic [31:0] hi, inout logic [31:0] lo);
		logic [31:0] r;
		logic [31:0] se;
		logic [31:0] ze;
		logic [4:0] sa;
		logic signed [63:0] sp;
		logic [63:0] up;
		mipsAluPkg::resultS out;
		se = {{16{w.iType.imm[15]}}, w.iType.imm};
		ze = {16'h0000, w.iType.imm};
		sa = w.rType.shamt;
		sp = longint'($signed(rs)) * longint'($signed(rt));
		up = {32'd0, rs} * {32'd0, rt};
		r  = 32'd1; // Anything unknown
		case (w.rType.opcode)
			mipsAluPkg::OpSpecial: begin
				case (w.rType.funct)
					mipsAluPkg::FnAdd, mipsAluPkg::FnAddu: r = rs + rt; // No traps
					mipsAluPkg::FnSub: r = rs - rt;
					mipsAluPkg::FnAnd: r = rs & rt;
					mipsAluPkg::FnOr:  r = rs | rt;
					mipsAluPkg::FnXor: r = rs ^ rt;
					mipsAluPkg::FnNor: r = ~(rs | rt);
					mipsAluPkg::FnSlt: r = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
					mipsAluPkg::FnSltu: r = (rs < rt) ? 32'd1 : 32'd0;
					mipsAluPkg::FnSll: r = rt << sa;
					mipsAluPkg::FnSra: r = $signed(rt) >>> sa;
					mipsAluPkg::FnSrl: begin
						if (w.rType.rs == 5'd0)
							r = rt >> sa;
						else if (w.rType.rs == 5'd1) // R bit set, rotate
							r = (sa == 5'd0) ? rt : ((rt >> sa) | (rt << (32 - sa)));
					end
					mipsAluPkg::FnMult: begin
						hi = sp[63:32];
						lo = sp[31:0];
						r  = sp[31:0];
					end
					mipsAluPkg::FnMultu: begin
						hi = up[63:32];
						lo = up[31:0];
						r  = up[31:0];
					end
					mipsAluPkg::FnMfhi: r = hi;
					mipsAluPkg::FnMflo: r = lo;
					default: ;
				endcase
			end
			mipsAluPkg::OpSpecial3: begin
				if (w.rType.funct == mipsAluPkg::FnBshfl && sa == mipsAluPkg::SaSeh)
					r = {{16{rt[15]}}, rt[15:0]};
				else if (w.rType.funct == mipsAluPkg::FnBshfl && sa == mipsAluPkg::SaSeb)
					r = {{24{rt[7]}}, rt[7:0]};
			end
			mipsAluPkg::OpAddi, mipsAluPkg::OpAddiu: r = rs + se;
			mipsAluPkg::OpSlti:  r = ($signed(rs) < $signed(se)) ? 32'd1 : 32'd0;
			mipsAluPkg::OpSltiu: r = (rs < se) ? 32'd1 : 32'd0; // Sext, unsigned compare
			mipsAluPkg::OpAndi:  r = rs & ze;
			mipsAluPkg::OpOri:   r = rs | ze;
			mipsAluPkg::OpXori:  r = rs ^ ze;
			default: ;
		endcase
		out.result = r;
		out.zero   = (r == 32'd0);
		return out;
	endfunction

	//////////////////////////////
	// Drivers
	//////////////////////////////

	task automatic sendItem(input string name, input mipsAluPkg::instrU w,
		input logic [31:0] a, input logic [31:0] b);
		mipsAluPkg::resultS exp;
		@(posedge Clk);
		#1;
		inVld  = 1'b1;
		instr  = w;
		rsData = a;
		rtData = b;
		exp = refModel(w, a, b, modelHi, modelLo); // Issue order equals retire order
		expQ.push_back(exp);
		nameQ.push_back(name);
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge Clk);
			#1;
			inVld = 1'b0;
		end
	endtask

	task automatic sendR(input string name, input logic [5:0] fn,
		input logic [31:0] a, input logic [31:0] b);
		mipsAluPkg::instrU w;
		w.rType = '{mipsAluPkg::OpSpecial, 5'd1, 5'd2, 5'd3, 5'd0, fn};
		sendItem(name, w, a, b);
	endtask

	task automatic sendShift(input string name, input logic [5:0] fn,
		input logic [4:0] rsSel, input logic [4:0] sa, input logic [31:0] value);
		mipsAluPkg::instrU w;
		w.rType = '{mipsAluPkg::OpSpecial, rsSel, 5'd2, 5'd3, sa, fn};
		sendItem(name, w, 32'h0bad_f00d, value); // rs data unused
	endtask

	task automatic sendImm(input string name, input logic [5:0] op,
		input logic [31:0] a, input logic [15:0] imm);
		mipsAluPkg::instrU w;
		w.iType = '{op, 5'd1, 5'd2, imm};
		sendItem(name, w, a, 32'h5a5a_5a5a);
	endtask

	task automatic sendExt(input string name, input logic [4:0] sa, input logic [31:0] value);
		mipsAluPkg::instrU w;
		w.rType = '{mipsAluPkg::OpSpecial3, 5'd0, 5'd2, 5'd3, sa, mipsAluPkg::FnBshfl};
		sendItem(name, w, 32'h0, value);
	endtask

	// In-flight items are dropped by the DUT, so the model drops them too
	task automatic pulseReset();
		@(posedge Clk);
		#1;
		reset = 1'b1;
		inVld = 1'b0;
		@(posedge Clk);
		#1;
		expQ.delete();
		nameQ.delete();
		modelHi = 32'd0;
		modelLo = 32'd0;
		@(posedge Clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic sendRandom(input int idx);
		mipsAluPkg::instrU w;
		logic [31:0] a;
		logic [31:0] b;
		int sel;
		rng = xorshift32(rng);
		w   = rng;
		rng = xorshift32(rng);
		a   = rng;
		rng = xorshift32(rng);
		b   = rng;
		rng = xorshift32(rng);
		sel = rng % 32;
		if (a[31:28] == 4'h0)
			b = a; // Equal operands, zero results now and then
		if (sel < 13) begin
			w.rType.opcode = mipsAluPkg::OpSpecial;
			w.rType.funct  = RegFns[sel*6 +: 6];
		end else if (sel < 20) begin
			w.iType.opcode = ImmOps[(sel-13)*6 +: 6];
		end else if (sel < 26) begin
			w.rType.opcode = mipsAluPkg::OpSpecial;
			w.rType.funct  = ShiftFns[(sel % 3)*6 +: 6];
			w.rType.rs     = {4'd0, sel[0]}; // srl or rotr
		end else if (sel < 30) begin
			w.rType.opcode = mipsAluPkg::OpSpecial3;
			w.rType.funct  = mipsAluPkg::FnBshfl;
			w.rType.shamt  = sel[0] ? mipsAluPkg::SaSeh : mipsAluPkg::SaSeb;
		end
		// Above 29 the raw word stays, mostly illegal
		sendItem($sformatf("random_%0d", idx), w, a, b);
		rng = xorshift32(rng);
		if (rng[2:0] == 3'd0)
			idleCycles(1 + rng[4:3]); // Short gap, else full rate
	endtask

	//////////////////////////////
	// Scoreboard
	//////////////////////////////

	task automatic checkResult(input string name, input mipsAluPkg::resultS exp,
		input mipsAluPkg::resultS act);
		if (act !== exp) begin
			valErrors++;
			$display("** Error: %s expected result=%h zero=%b, actual result=%h zero=%b",
				name, exp.result, exp.zero, act.result, act.zero);
		end
	endtask

	always @(negedge Clk) begin // Outputs settled mid-cycle
		if (outVld === 1'b1) begin
			if (expQ.size() == 0) begin
				otherErrors++;
				$display("outVld went high at %0t with no item outstanding", $time);
			end else begin
				checkResult(nameQ.pop_front(), expQ.pop_front(), res);
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles <= CycleLimit) begin
			@(posedge Clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, results still missing", CycleLimit);
		$display("Simulation finished: FAIL");
		$finish;
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		reset       = 1'b1;
		inVld       = 1'b0;
		instr       = '0;
		rsData      = 32'd0;
		rtData      = 32'd0;
		modelHi     = 32'd0;
		modelLo     = 32'd0;
		rng         = 32'h9ba476d2;
		valErrors   = 0;
		otherErrors = 0;
		repeat (2) @(posedge Clk);
		#1;
		reset = 1'b0;

		// Arithmetic and compares at the boundaries
		sendR("add_small", mipsAluPkg::FnAdd, 32'd7, 32'd8);
		sendR("add_wrap", mipsAluPkg::FnAdd, 32'h7fff_ffff, 32'd1);
		sendR("sub_zero", mipsAluPkg::FnSub, 32'd5, 32'd5);
		sendR("sub_neg", mipsAluPkg::FnSub, 32'd0, 32'd1);
		sendR("addu_wrap", mipsAluPkg::FnAddu, 32'hffff_ffff, 32'd1);
		sendR("slt_min_max", mipsAluPkg::FnSlt, 32'h8000_0000, 32'h7fff_ffff);
		sendR("slt_max_min", mipsAluPkg::FnSlt, 32'h7fff_ffff, 32'h8000_0000);
		sendR("sltu_min_max", mipsAluPkg::FnSltu, 32'h8000_0000, 32'h7fff_ffff);
		sendR("sltu_zero_max", mipsAluPkg::FnSltu, 32'd0, 32'hffff_ffff);
		idleCycles(4);

		// Logic, shifts, rotates, extends
		sendR("and_mix", mipsAluPkg::FnAnd, 32'hf0f0_1234, 32'h0ff0_ff00);
		sendR("or_mix", mipsAluPkg::FnOr, 32'hf000_0001, 32'h0000_8000);
		sendR("xor_self", mipsAluPkg::FnXor, 32'hdead_beef, 32'hdead_beef);
		sendR("nor_ones", mipsAluPkg::FnNor, 32'hffff_0000, 32'h0000_ffff);
		sendShift("sll_4", mipsAluPkg::FnSll, 5'd0, 5'd4, 32'h8765_4321);
		sendShift("srl_31", mipsAluPkg::FnSrl, 5'd0, 5'd31, 32'h8000_0000);
		sendShift("sra_neg_31", mipsAluPkg::FnSra, 5'd0, 5'd31, 32'h8000_0000);
		sendShift("rotr_0", mipsAluPkg::FnSrl, 5'd1, 5'd0, 32'h1234_5678);
		sendShift("rotr_31", mipsAluPkg::FnSrl, 5'd1, 5'd31, 32'h8000_0001);
		sendShift("rotr_8", mipsAluPkg::FnSrl, 5'd1, 5'd8, 32'h1234_5678);
		sendExt("seh_neg", mipsAluPkg::SaSeh, 32'h1234_8000);
		sendExt("seh_pos", mipsAluPkg::SaSeh, 32'hffff_7fff);
		sendExt("seb_neg", mipsAluPkg::SaSeb, 32'h0000_0080);
		sendExt("seb_pos", mipsAluPkg::SaSeb, 32'hffff_ff7f);
		idleCycles(4);

		// Immediates, sign vs zero extension
		sendImm("addi_neg", mipsAluPkg::OpAddi, 32'd1, 16'hffff);
		sendImm("addiu_sext", mipsAluPkg::OpAddiu, 32'h0001_0000, 16'h8000);
		sendImm("slti_neg", mipsAluPkg::OpSlti, 32'hffff_fffb, 16'hfffd);
		sendImm("sltiu_sext", mipsAluPkg::OpSltiu, 32'd5, 16'hffff);
		sendImm("andi_zext", mipsAluPkg::OpAndi, 32'hffff_ffff, 16'h8001);
		sendImm("ori_zext", mipsAluPkg::OpOri, 32'd0, 16'hffff);
		sendImm("xori_zext", mipsAluPkg::OpXori, 32'hffff_ffff, 16'hffff);
		idleCycles(4);

		// HI/LO read back right after and later
		sendR("mult_signed", mipsAluPkg::FnMult, 32'hffff_fffd, 32'd7);
		sendR("mfhi_b2b", mipsAluPkg::FnMfhi, 32'd0, 32'd0);
		sendR("mflo_b2b", mipsAluPkg::FnMflo, 32'd0, 32'd0);
		sendR("multu_max", mipsAluPkg::FnMultu, 32'hffff_ffff, 32'hffff_ffff);
		sendR("mfhi_b2b_u", mipsAluPkg::FnMfhi, 32'd0, 32'd0);
		sendR("mflo_b2b_u", mipsAluPkg::FnMflo, 32'd0, 32'd0);
		idleCycles(4);
		sendR("mfhi_later", mipsAluPkg::FnMfhi, 32'd0, 32'd0);
		sendR("mflo_later", mipsAluPkg::FnMflo, 32'd0, 32'd0);
		idleCycles(4);

		// Illegal words, then reset with items in flight
		sendItem("illegal_opcode", 32'hfc00_0000, 32'd3, 32'd4);
		sendR("illegal_funct", 6'b111111, 32'd3, 32'd4);
		sendShift("illegal_srl_rs", mipsAluPkg::FnSrl, 5'd2, 5'd3, 32'h0000_00f0);
		sendR("mult_before_reset", mipsAluPkg::FnMult, 32'h0001_0003, 32'h0001_0000);
		sendR("add_dropped_a", mipsAluPkg::FnAdd, 32'd1, 32'd1);
		sendR("add_dropped_b", mipsAluPkg::FnAdd, 32'd2, 32'd2);
		pulseReset();
		sendR("mfhi_after_reset", mipsAluPkg::FnMfhi, 32'd0, 32'd0);
		sendR("mflo_after_reset", mipsAluPkg::FnMflo, 32'd0, 32'd0);
		idleCycles(4);

		for (int i = 0; i < NumRandom; i++)
			sendRandom(i);
		idleCycles(8); // Drain

		if (expQ.size() != 0) begin
			otherErrors++;
			$display("%0d expected results never came out", expQ.size());
		end
		$display("Errors: %0d value, %0d other, %0d assertion",
			valErrors, otherErrors, u_dut.uAsserts.assertFails);
		if (valErrors == 0 && otherErrors == 0 && u_dut.uAsserts.assertFails == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: dv/aluExecTb_asserts.sv
`timescale 1ns/1ns

module aluExecTb_asserts (
	input logic               Clk,
	input logic               reset,
	input logic               inVld,
	input logic               outVld,
	input mipsAluPkg::resultS res
);

	int assertFails = 0; // Summed into the closing line

	// Sync reset clears outVld on the following edge
	outVldLowInReset: assert property (@(posedge Clk) reset |=> !outVld)
		else begin
			assertFails++;
			$error("outVld high after a reset cycle");
		end

	//////////////////////////////
	// Three stage latency
	//////////////////////////////

	inToOut: assert property (@(posedge Clk) disable iff (reset) inVld |-> ##3 outVld)
		else begin
			assertFails++;
			$error("item accepted but no outVld three cycles later");
		end

	outFromIn: assert property (@(posedge Clk) disable iff (reset) outVld |-> $past(inVld, 3))
		else begin
			assertFails++;
			$error("outVld without an item three cycles earlier");
		end

	zeroFlag: assert property (@(posedge Clk) disable iff (reset)
		outVld |-> (res.zero == (res.result == 32'd0)))
		else begin
			assertFails++;
			$error("zero flag disagrees with result");
		end

endmodule

bind aluExecTop aluExecTb_asserts uAsserts (
	.Clk    (Clk),
	.reset  (reset),
	.inVld  (inVld),
	.outVld (outVld),
	.res    (res)
);

// File: filelist.f
hw/mipsAluPkg.sv
hw/instrDecode.sv
hw/alu32.sv
hw/hiLoResult.sv
hw/aluExecTop.sv
dv/aluExecTb_asserts.sv
dv/aluExecTb.sv

// File: hw/alu32.sv
`timescale 1ns/1ns

module alu32 (
	input  logic                 Clk,
	input  logic                 reset,
	input  mipsAluPkg::execReqS  req,
	output mipsAluPkg::execRespS resp
);

	logic signed [63:0] prodSigned;
	logic [63:0] prodUnsigned;
	logic [63:0] rotWide;
	logic [31:0] nextLo;
	logic [31:0] nextHi;

	// Full 64-bit products for the HI/LO pair
	assign prodSigned   = $signed(req.a) * $signed(req.b);
	assign prodUnsigned = req.a * req.b;

	// Doubled word shifted right gives a rotate in the low half
	assign rotWide = {req.a, req.a} >> req.b[4:0];

	//////////////////////////////
	// Operation select
	//////////////////////////////

	always_comb begin
		nextLo = 32'd0;
		nextHi = 32'd0; // Only multiplies fill hi
		case (req.op)
			mipsAluPkg::AluAdd:  nextLo = $signed(req.a) + $signed(req.b);
			mipsAluPkg::AluSub:  nextLo = $signed(req.a) - $signed(req.b);
			mipsAluPkg::AluMult: begin
				nextLo = prodSigned[31:0];
				nextHi = prodSigned[63:32];
			end
			mipsAluPkg::AluAnd:  nextLo = req.a & req.b;
			mipsAluPkg::AluOr:   nextLo = req.a | req.b;
			mipsAluPkg::AluXor:  nextLo = req.a ^ req.b;
			mipsAluPkg::AluNor:  nextLo = ~(req.a | req.b);
			// Shift amount never exceeds 31 here
			mipsAluPkg::AluSll:  nextLo = req.a << req.b[4:0];
			mipsAluPkg::AluSrl:  nextLo = req.a >> req.b[4:0];
			mipsAluPkg::AluRotr: nextLo = rotWide[31:0]; // B mod 32
			mipsAluPkg::AluSra:  nextLo = $signed(req.a) >>> req.b[4:0];
			mipsAluPkg::AluSeh:  nextLo = {{16{req.a[15]}}, req.a[15:0]};
			mipsAluPkg::AluAddu: nextLo = req.a + req.b;
			mipsAluPkg::AluMultu: begin
				nextLo = prodUnsigned[31:0];
				nextHi = prodUnsigned[63:32];
			end
			mipsAluPkg::AluSlt:  nextLo = {31'd0, $signed(req.a) < $signed(req.b)};
			mipsAluPkg::AluSeb:  nextLo = {{24{req.a[7]}}, req.a[7:0]};
			mipsAluPkg::AluSltu: nextLo = {31'd0, req.a < req.b};
			// HI/LO read happens one stage later
			mipsAluPkg::AluMfhi,
			mipsAluPkg::AluMflo: nextLo = 32'd0;
			default:             nextLo = 32'd1; // Illegal, legacy default
		endcase
	end

	// Execute stage register
	always_ff @(posedge Clk) begin
		resp.op <= req.op;
		resp.lo <= nextLo;
		resp.hi <= nextHi;
		if (reset)
			resp.vld <= 1'b0;
		else
			resp.vld <= req.vld;
	end

endmodule

// File: hw/aluExecTop.sv
`timescale 1ns/1ns

module aluExecTop (
	input  logic               Clk,
	input  logic               reset,
	input  logic               inVld,
	input  mipsAluPkg::instrU  instr,
	input  logic [31:0]        rsData,
	input  logic [31:0]        rtData,
	output logic               outVld,
	output mipsAluPkg::resultS res
);

	mipsAluPkg::execReqS  req;  // Decode -> execute
	mipsAluPkg::execRespS resp; // Execute -> result

	//////////////////////////////
	// Three stage execute path
	//////////////////////////////

	instrDecode uDecode (
		.Clk    (Clk),
		.reset  (reset),
		.inVld  (inVld),
		.instr  (instr),
		.rsData (rsData),
		.rtData (rtData),
		.req    (req)
	);

	alu32 uAlu (
		.Clk   (Clk),
		.reset (reset),
		.req   (req),
		.resp  (resp)
	);

	hiLoResult uResult (
		.Clk    (Clk),
		.reset  (reset),
		.resp   (resp),
		.outVld (outVld),
		.res    (res)
	);

endmodule

// File: hw/hiLoResult.sv
`timescale 1ns/1ns

module hiLoResult (
	input  logic                 Clk,
	input  logic                 reset,
	input  mipsAluPkg::execRespS resp,
	output logic                 outVld,
	output mipsAluPkg::resultS   res
);

	logic [31:0] hiReg;
	logic [31:0] loReg;
	logic [31:0] resultNext;
	logic        isMult;

	assign isMult = (resp.op == mipsAluPkg::AluMult) || (resp.op == mipsAluPkg::AluMultu);

	//////////////////////////////
	// HI / LO state
	//////////////////////////////

	always_ff @(posedge Clk) begin
		if (reset) begin
			hiReg <= 32'd0;
			loReg <= 32'd0;
		end else if (resp.vld && isMult) begin // Only real items write
			hiReg <= resp.hi;
			loReg <= resp.lo;
		end
	end

	// mfhi/mflo see the last multiply already committed
	always_comb begin
		case (resp.op)
			mipsAluPkg::AluMfhi: resultNext = hiReg;
			mipsAluPkg::AluMflo: resultNext = loReg;
			default:             resultNext = resp.lo; // Multiplies return LO too
		endcase
	end

	// Output register
	always_ff @(posedge Clk) begin
		res.result <= resultNext;
		res.zero   <= (resultNext == 32'd0);
		if (reset)
			outVld <= 1'b0;
		else
			outVld <= resp.vld;
	end

endmodule

// File: hw/instrDecode.sv
`timescale 1ns/1ns

module instrDecode (
	input  logic                 Clk,
	input  logic                 reset,
	input  logic                 inVld,
	input  mipsAluPkg::instrU    instr,
	input  logic [31:0]          rsData,
	input  logic [31:0]          rtData,
	output mipsAluPkg::execReqS  req
);

	mipsAluPkg::aluOpE decOp;
	logic [31:0] decA;
	logic [31:0] decB;
	logic [31:0] shamtExt;
	logic [31:0] immSext;
	logic [31:0] immZext;

	assign shamtExt = {27'd0, instr.rType.shamt};
	assign immSext  = {{16{instr.iType.imm[15]}}, instr.iType.imm};
	assign immZext  = {16'd0, instr.iType.imm}; // Logic immediates

	//////////////////////////////
	// Opcode / funct decode
	//////////////////////////////

	always_comb begin
		decOp = mipsAluPkg::AluIllegal; // Fallback for anything unmatched
		decA  = rsData;
		decB  = rtData;
		case (instr.rType.opcode)
			mipsAluPkg::OpSpecial: begin
				case (instr.rType.funct)
					mipsAluPkg::FnAdd:   decOp = mipsAluPkg::AluAdd;
					mipsAluPkg::FnAddu:  decOp = mipsAluPkg::AluAddu;
					mipsAluPkg::FnSub:   decOp = mipsAluPkg::AluSub;
					mipsAluPkg::FnAnd:   decOp = mipsAluPkg::AluAnd;
					mipsAluPkg::FnOr:    decOp = mipsAluPkg::AluOr;
					mipsAluPkg::FnXor:   decOp = mipsAluPkg::AluXor;
					mipsAluPkg::FnNor:   decOp = mipsAluPkg::AluNor;
					mipsAluPkg::FnSlt:   decOp = mipsAluPkg::AluSlt;
					mipsAluPkg::FnSltu:  decOp = mipsAluPkg::AluSltu;
					mipsAluPkg::FnMult:  decOp = mipsAluPkg::AluMult;
					mipsAluPkg::FnMultu: decOp = mipsAluPkg::AluMultu;
					mipsAluPkg::FnMfhi:  decOp = mipsAluPkg::AluMfhi;
					mipsAluPkg::FnMflo:  decOp = mipsAluPkg::AluMflo;
					// Shifts work on rt by the shamt field
					mipsAluPkg::FnSll: begin
						decOp = mipsAluPkg::AluSll;
						decA  = rtData;
						decB  = shamtExt;
					end
					mipsAluPkg::FnSrl: begin
						decA = rtData;
						decB = shamtExt;
						if (instr.rType.rs == 5'd1)
							decOp = mipsAluPkg::AluRotr; // rotr shares funct with srl
						else if (instr.rType.rs == 5'd0)
							decOp = mipsAluPkg::AluSrl;
					end
					mipsAluPkg::FnSra: begin
						decOp = mipsAluPkg::AluSra;
						decA  = rtData;
						decB  = shamtExt;
					end
					default: ;
				endcase
			end
			mipsAluPkg::OpSpecial3: begin
				decA = rtData; // seb / seh extend rt
				if (instr.rType.funct == mipsAluPkg::FnBshfl) begin
					if (instr.rType.shamt == mipsAluPkg::SaSeh)
						decOp = mipsAluPkg::AluSeh;
					else if (instr.rType.shamt == mipsAluPkg::SaSeb)
						decOp = mipsAluPkg::AluSeb;
				end
			end
			// Immediate forms, I view of the word
			mipsAluPkg::OpAddi: begin
				decOp = mipsAluPkg::AluAdd;
				decB  = immSext;
			end
			mipsAluPkg::OpAddiu: begin
				decOp = mipsAluPkg::AluAddu;
				decB  = immSext; // Still sign extended
			end
			mipsAluPkg::OpSlti: begin
				decOp = mipsAluPkg::AluSlt;
				decB  = immSext;
			end
			mipsAluPkg::OpSltiu: begin
				decOp = mipsAluPkg::AluSltu;
				decB  = immSext; // Sext then unsigned compare
			end
			mipsAluPkg::OpAndi: begin
				decOp = mipsAluPkg::AluAnd;
				decB  = immZext;
			end
			mipsAluPkg::OpOri: begin
				decOp = mipsAluPkg::AluOr;
				decB  = immZext;
			end
			mipsAluPkg::OpXori: begin
				decOp = mipsAluPkg::AluXor;
				decB  = immZext;
			end
			default: ;
		endcase
	end

	// Stage register
	always_ff @(posedge Clk) begin
		req.op <= decOp;
		req.a  <= decA;
		req.b  <= decB;
		if (reset)
			req.vld <= 1'b0;
		else
			req.vld <= inVld;
	end

endmodule

// File: hw/mipsAluPkg.sv
package mipsAluPkg;

	//////////////////////////////
	// ALU operation codes
	//////////////////////////////

	// 0..16 follow the classic ALU control table
	typedef enum logic [4:0] {
		AluAdd     = 5'd0,
		AluSub     = 5'd1,
		AluMult    = 5'd2,
		AluAnd     = 5'd3,
		AluOr      = 5'd4,
		AluXor     = 5'd5,
		AluNor     = 5'd6,
		AluSll     = 5'd7,
		AluSrl     = 5'd8,
		AluRotr    = 5'd9,
		AluSra     = 5'd10,
		AluSeh     = 5'd11,
		AluAddu    = 5'd12,
		AluMultu   = 5'd13,
		AluSlt     = 5'd14,
		AluSeb     = 5'd15,
		AluSltu    = 5'd16,
		AluMfhi    = 5'd17, // Read back HI
		AluMflo    = 5'd18, // Read back LO
		AluIllegal = 5'd19  // Unknown encoding, result is one
	} aluOpE;

	//////////////////////////////
	// Instruction word views
	//////////////////////////////

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt; // Also the BSHFL selector
		logic [5:0] funct;
	} rTypeS;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iTypeS;

	// Same 32 bits, R view or I view
	typedef union packed {
		rTypeS rType;
		iTypeS iType;
	} instrU;

	// Major opcodes
	localparam logic [5:0] OpSpecial  = 6'b000000;
	localparam logic [5:0] OpSpecial3 = 6'b011111;
	localparam logic [5:0] OpAddi     = 6'b001000;
	localparam logic [5:0] OpAddiu    = 6'b001001;
	localparam logic [5:0] OpSlti     = 6'b001010;
	localparam logic [5:0] OpSltiu    = 6'b001011;
	localparam logic [5:0] OpAndi     = 6'b001100;
	localparam logic [5:0] OpOri      = 6'b001101;
	localparam logic [5:0] OpXori     = 6'b001110;

	// SPECIAL funct field
	localparam logic [5:0] FnSll   = 6'b000000;
	localparam logic [5:0] FnSrl   = 6'b000010; // rs=1 selects rotr
	localparam logic [5:0] FnSra   = 6'b000011;
	localparam logic [5:0] FnMfhi  = 6'b010000;
	localparam logic [5:0] FnMflo  = 6'b010010;
	localparam logic [5:0] FnMult  = 6'b011000;
	localparam logic [5:0] FnMultu = 6'b011001;
	localparam logic [5:0] FnAdd   = 6'b100000;
	localparam logic [5:0] FnAddu  = 6'b100001;
	localparam logic [5:0] FnSub   = 6'b100010;
	localparam logic [5:0] FnAnd   = 6'b100100;
	localparam logic [5:0] FnOr    = 6'b100101;
	localparam logic [5:0] FnXor   = 6'b100110;
	localparam logic [5:0] FnNor   = 6'b100111;
	localparam logic [5:0] FnSlt   = 6'b101010;
	localparam logic [5:0] FnSltu  = 6'b101011;

	// SPECIAL3 BSHFL, sub-op in the shamt slot
	localparam logic [5:0] FnBshfl = 6'b100000;
	localparam logic [4:0] SaSeb   = 5'b10000;
	localparam logic [4:0] SaSeh   = 5'b11000;

	//////////////////////////////
	// Stage payloads
	//////////////////////////////

	typedef struct packed {
		aluOpE       op;
		logic [31:0] a;
		logic [31:0] b;
		logic        vld;
	} execReqS;

	typedef struct packed {
		aluOpE       op;
		logic [31:0] lo; // Result, or low product half
		logic [31:0] hi; // High product half
		logic        vld;
	} execRespS;

	typedef struct packed {
		logic [31:0] result;
		logic        zero;
	} resultS;

endpackage
